// ==== Bender.yml ====
package:
  name: n64_ppu

sources:
  - include_dirs:
      - .
    files:
      - n64_ppu_pkg.sv
      - n64_vdemux.sv
      - n64_scanline_emu.sv
      - ppu_credit_tx.sv
      - n64_ppu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_n64_ppu_top.sv

// ==== n64_ppu_defs.svh ====
// Global widths and sizes of the N64 video pixel pipeline
// PPU_BUF_DEPTH must be a power of two, because the buffer pointers wrap freely
// PPU_TX_CREDITS must match the slot count of the downstream receiver

`ifndef N64_PPU_DEFS_SVH
`define N64_PPU_DEFS_SVH

// Colour width on the N64 video bus
`define N64_COLOR_W     7

// Colour width towards the video transmitter
`define PPU_COLOR_W     8

// Sync bits travelling with each pixel
`define PPU_SYNC_W      4

// Scanline strength, 256 steps
`define PPU_SL_STR_W    8

// Output buffer and downstream receiver sizes
`define PPU_BUF_DEPTH   4
`define PPU_TX_CREDITS  4

`endif

// ==== n64_ppu_pkg.sv ====
// Types shared by the N64 video pixel pipeline
// Bus word views assume the usual N64 layout with sync bits in the lower nibble

`include "n64_ppu_defs.svh"

package n64_ppu_pkg;

  // One word of the N64 video bus, decoded as sync bits or as a colour
  typedef union packed {
    logic [`N64_COLOR_W-1:0] color;
    struct packed {
      logic [`N64_COLOR_W-`PPU_SYNC_W-1:0] rsvd;
      logic nvsync;
      logic nclamp;
      logic nhsync;
      logic ncsync;
    } sync;
  } n64_vbus_t;

  // Bit positions inside every sync field of the pipeline
  localparam int SYNC_NVSYNC = 3;
  localparam int SYNC_NCLAMP = 2;
  localparam int SYNC_NHSYNC = 1;
  localparam int SYNC_NCSYNC = 0;

endpackage

// ==== n64_ppu_top.f ====
+incdir+.
n64_ppu_pkg.sv
n64_vdemux.sv
n64_scanline_emu.sv
ppu_credit_tx.sv
n64_ppu_top.sv
tb_n64_ppu_top.sv

// ==== n64_ppu_top.sv ====
// N64 video input pipeline: bus demux, scanline emulation, credit based output
// All stages run on N64_CLK_i, no clock domain crossing inside
// VD_o carries red in the upper byte

`timescale 1ns/1ns

`include "n64_ppu_defs.svh"

module n64_ppu_top (
  input  logic                        N64_CLK_i,
  input  logic                        arst_n_i,
  input  logic                        nVDSYNC_i,
  input  n64_ppu_pkg::n64_vbus_t      VD_i,
  input  logic                        n16bit_mode_i,
  input  logic                        sl_en_i,
  input  logic [`PPU_SL_STR_W-1:0]    sl_str_i,
  input  logic                        credit_return_i,
  output logic                        vd_valid_o,
  output logic [3*`PPU_COLOR_W-1:0]   VD_o,
  output logic [`PPU_SYNC_W-1:0]      sync_o,
  output logic                        overflow_o
);

  // Demux to scanline stage
  logic                      pix_valid;
  logic [`PPU_SYNC_W-1:0]    pix_sync;
  logic [`N64_COLOR_W-1:0]   pix_r;
  logic [`N64_COLOR_W-1:0]   pix_g;
  logic [`N64_COLOR_W-1:0]   pix_b;

  // Scanline stage to output buffer
  logic                      sl_valid;
  logic [`PPU_SYNC_W-1:0]    sl_sync;
  logic [3*`PPU_COLOR_W-1:0] sl_rgb;

  // ==========================================================
  // Input side
  // ==========================================================

  n64_vdemux vdemux_i (
    .N64_CLK_i   (N64_CLK_i),
    .arst_n_i    (arst_n_i),
    .nVDSYNC_i   (nVDSYNC_i),
    .VD_i        (VD_i),
    .pix_valid_o (pix_valid),
    .pix_sync_o  (pix_sync),
    .pix_r_o     (pix_r),
    .pix_g_o     (pix_g),
    .pix_b_o     (pix_b)
  );

  // ==========================================================
  // Processing and output side
  // ==========================================================

  n64_scanline_emu scanline_emu_i (
    .N64_CLK_i     (N64_CLK_i),
    .arst_n_i      (arst_n_i),
    .pix_valid_i   (pix_valid),
    .pix_sync_i    (pix_sync),
    .pix_r_i       (pix_r),
    .pix_g_i       (pix_g),
    .pix_b_i       (pix_b),
    .n16bit_mode_i (n16bit_mode_i),
    .sl_en_i       (sl_en_i),
    .sl_str_i      (sl_str_i),
    .sl_valid_o    (sl_valid),
    .sl_sync_o     (sl_sync),
    .sl_rgb_o      (sl_rgb)
  );

  ppu_credit_tx credit_tx_i (
    .N64_CLK_i       (N64_CLK_i),
    .arst_n_i        (arst_n_i),
    .sl_valid_i      (sl_valid),
    .sl_sync_i       (sl_sync),
    .sl_rgb_i        (sl_rgb),
    .credit_return_i (credit_return_i),
    .vd_valid_o      (vd_valid_o),
    .VD_o            (VD_o),
    .sync_o          (sync_o),
    .overflow_o      (overflow_o)
  );

endmodule

// ==== n64_scanline_emu.sv ====
// Colour reduction, 7 to 8 bit expansion and horizontal scanline emulation
// n16bit_mode_i high selects 16-bit colour, despite its name
// Lines are counted from the nHSYNC falling edge, nVSYNC falling resets to even

`timescale 1ns/1ns

`include "n64_ppu_defs.svh"

module n64_scanline_emu (
  input  logic                          N64_CLK_i,
  input  logic                          arst_n_i,
  input  logic                          pix_valid_i,
  input  logic [`PPU_SYNC_W-1:0]        pix_sync_i,
  input  logic [`N64_COLOR_W-1:0]       pix_r_i,
  input  logic [`N64_COLOR_W-1:0]       pix_g_i,
  input  logic [`N64_COLOR_W-1:0]       pix_b_i,
  input  logic                          n16bit_mode_i,
  input  logic                          sl_en_i,
  input  logic [`PPU_SL_STR_W-1:0]      sl_str_i,
  output logic                          sl_valid_o,
  output logic [`PPU_SYNC_W-1:0]        sl_sync_o,
  output logic [3*`PPU_COLOR_W-1:0]     sl_rgb_o
);

  import n64_ppu_pkg::*;

  logic line_odd_q;
  logic line_odd_d;
  logic hs_prev_q;
  logic vs_prev_q;
  logic dim;

  // Reduce, expand and optionally dim one colour
  function automatic logic [`PPU_COLOR_W-1:0] color_proc(
    input logic [`N64_COLOR_W-1:0]  c_in,
    input logic                     reduce,
    input logic                     dim_en,
    input logic [`PPU_SL_STR_W-1:0] str
  );
    logic [`N64_COLOR_W-1:0]               c_red;
    logic [`PPU_COLOR_W-1:0]               c_exp;
    logic [`PPU_COLOR_W+`PPU_SL_STR_W-1:0] prod;
    c_red = c_in;
    if (reduce)
      c_red[1:0] = 2'b00;
    // MSB replication fills the extra bit
    c_exp = {c_red, c_red[`N64_COLOR_W-1]};
    prod  = c_exp * str;
    if (dim_en)
      return c_exp - prod[`PPU_COLOR_W+`PPU_SL_STR_W-1:`PPU_SL_STR_W];
    return c_exp;
  endfunction

  // ==========================================================
  // Line parity
  // ==========================================================

  // The pixel that opens a line already belongs to it
  always_comb begin
    line_odd_d = line_odd_q;
    if (!pix_sync_i[SYNC_NVSYNC] && vs_prev_q)
      line_odd_d = 1'b0;
    else if (!pix_sync_i[SYNC_NHSYNC] && hs_prev_q)
      line_odd_d = ~line_odd_q;
  end

  assign dim = sl_en_i & line_odd_d;

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      line_odd_q <= 1'b0;
      hs_prev_q  <= 1'b1;
      vs_prev_q  <= 1'b1;
      sl_valid_o <= 1'b0;
    end else begin
      sl_valid_o <= pix_valid_i;
      if (pix_valid_i) begin
        line_odd_q <= line_odd_d;
        hs_prev_q  <= pix_sync_i[SYNC_NHSYNC];
        vs_prev_q  <= pix_sync_i[SYNC_NVSYNC];
      end
    end
  end

  // ==========================================================
  // Pixel register
  // ==========================================================

  always_ff @(posedge N64_CLK_i) begin
    if (pix_valid_i) begin
      sl_sync_o <= pix_sync_i;
      sl_rgb_o  <= {color_proc(pix_r_i, n16bit_mode_i, dim, sl_str_i),
                    color_proc(pix_g_i, n16bit_mode_i, dim, sl_str_i),
                    color_proc(pix_b_i, n16bit_mode_i, dim, sl_str_i)};
    end
  end

endmodule

// ==== n64_vdemux.sv ====
// Demultiplexes the N64 video bus into pixels
// Expects one sync word (nVDSYNC_i low) followed by red, green and blue words
// A sync word always restarts the sequence, a partial group is discarded

`timescale 1ns/1ns

`include "n64_ppu_defs.svh"

module n64_vdemux (
  input  logic                        N64_CLK_i,
  input  logic                        arst_n_i,
  input  logic                        nVDSYNC_i,
  input  n64_ppu_pkg::n64_vbus_t      VD_i,
  output logic                        pix_valid_o,
  output logic [`PPU_SYNC_W-1:0]      pix_sync_o,
  output logic [`N64_COLOR_W-1:0]     pix_r_o,
  output logic [`N64_COLOR_W-1:0]     pix_g_o,
  output logic [`N64_COLOR_W-1:0]     pix_b_o
);

  import n64_ppu_pkg::*;

  // Phase 0 is idle, 1 to 3 expect red, green and blue
  logic [1:0]              phase_q;

  // Staging for the group in progress
  logic [`PPU_SYNC_W-1:0]  sync_q;
  logic [`N64_COLOR_W-1:0] r_q;
  logic [`N64_COLOR_W-1:0] g_q;

  // ==========================================================
  // Phase counter and valid
  // ==========================================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q     <= 2'd0;
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= 1'b0;
      if (!nVDSYNC_i) begin
        phase_q <= 2'd1;
      end else if (phase_q != 2'd0) begin
        // Wraps back to idle after the blue word
        phase_q <= phase_q + 2'd1;
        if (phase_q == 2'd3)
          pix_valid_o <= 1'b1;
      end
    end
  end

  // ==========================================================
  // Data capture
  // ==========================================================

  always_ff @(posedge N64_CLK_i) begin
    if (!nVDSYNC_i) begin
      sync_q[SYNC_NVSYNC] <= VD_i.sync.nvsync;
      sync_q[SYNC_NCLAMP] <= VD_i.sync.nclamp;
      sync_q[SYNC_NHSYNC] <= VD_i.sync.nhsync;
      sync_q[SYNC_NCSYNC] <= VD_i.sync.ncsync;
    end else begin
      case (phase_q)
        2'd1: r_q <= VD_i.color;
        2'd2: g_q <= VD_i.color;
        2'd3: begin
          // Whole pixel moves to the outputs at once
          pix_sync_o <= sync_q;
          pix_r_o    <= r_q;
          pix_g_o    <= g_q;
          pix_b_o    <= VD_i.color;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== ppu_credit_tx.sv ====
// Pixel buffer with credit based flow control towards the video transmitter
// The N64 source cannot stall, so a pixel arriving at a full buffer is lost
// and overflow_o stays set until reset
// An empty buffer with credit passes the incoming pixel straight through

`timescale 1ns/1ns

`include "n64_ppu_defs.svh"

module ppu_credit_tx (
  input  logic                       N64_CLK_i,
  input  logic                       arst_n_i,
  input  logic                       sl_valid_i,
  input  logic [`PPU_SYNC_W-1:0]     sl_sync_i,
  input  logic [3*`PPU_COLOR_W-1:0]  sl_rgb_i,
  input  logic                       credit_return_i,
  output logic                       vd_valid_o,
  output logic [3*`PPU_COLOR_W-1:0]  VD_o,
  output logic [`PPU_SYNC_W-1:0]     sync_o,
  output logic                       overflow_o
);

  localparam int PTR_W = $clog2(`PPU_BUF_DEPTH);
  localparam int CNT_W = $clog2(`PPU_BUF_DEPTH + 1);
  localparam int CRD_W = $clog2(`PPU_TX_CREDITS + 1);
  localparam int PIX_W = `PPU_SYNC_W + 3*`PPU_COLOR_W;

  logic [PIX_W-1:0] buf_mem [`PPU_BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CRD_W-1:0] credits_q;

  logic             buf_empty;
  logic             buf_full;
  logic             has_credit;
  logic             send;
  logic             push;
  logic             pop;
  logic             drop;
  logic [PIX_W-1:0] in_pix;
  logic [PIX_W-1:0] head_pix;

  assign in_pix     = {sl_sync_i, sl_rgb_i};
  assign buf_empty  = (count_q == '0);
  assign buf_full   = (count_q == CNT_W'(`PPU_BUF_DEPTH));
  assign has_credit = (credits_q != '0);

  // Oldest pixel first, the input only when nothing is waiting
  assign head_pix = buf_empty ? in_pix : buf_mem[rd_ptr_q];
  assign send     = has_credit & (~buf_empty | sl_valid_i);
  assign pop      = send & ~buf_empty;
  assign drop     = sl_valid_i & buf_full;
  assign push     = sl_valid_i & ~buf_full & ~(buf_empty & has_credit);

  // ==========================================================
  // Buffer and credit control
  // ==========================================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      credits_q  <= CRD_W'(`PPU_TX_CREDITS);
      vd_valid_o <= 1'b0;
      overflow_o <= 1'b0;
    end else begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
      // Send and return in one cycle cancel out
      case ({send, credit_return_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: ;
      endcase
      vd_valid_o <= send;
      if (drop)
        overflow_o <= 1'b1;
    end
  end

  // ==========================================================
  // Storage and output register
  // ==========================================================

  always_ff @(posedge N64_CLK_i) begin
    if (push)
      buf_mem[wr_ptr_q] <= in_pix;
    if (send)
      {sync_o, VD_o} <= head_pix;
  end

endmodule

// ==== tb_n64_ppu_top.sv ====
// Random N64 bus traffic against a cycle based model of the pipeline
// The model predicts send timing, credits and drops, so every output cycle is checked
// Stops at the first mismatch

`timescale 1ns/1ns

`include "n64_ppu_defs.svh"

module tb_n64_ppu_top;

  import n64_ppu_pkg::*;

  localparam int PIX_W          = `PPU_SYNC_W + 3*`PPU_COLOR_W;
  localparam int N_GROUPS       = 160;
  // Worst case per group is four bus words and three idle words
  localparam int PLANNED_CYCLES = N_GROUPS * 7;
  localparam int TIMEOUT_CYCLES = 4 * PLANNED_CYCLES + 200;

  logic                        clk = 1'b0;
  logic                        arst_n;
  logic                        nvdsync;
  n64_vbus_t                   vd_bus;
  logic                        n16bit;
  logic                        sl_en;
  logic [`PPU_SL_STR_W-1:0]    sl_str;
  logic                        credit_return;
  logic                        vd_valid_o;
  logic [3*`PPU_COLOR_W-1:0]   VD_o;
  logic [`PPU_SYNC_W-1:0]      sync_o;
  logic                        overflow_o;

  logic [31:0]      lcg_state = 32'h815ae3da;
  int               cycle_cnt = 0;
  int               reset_edges = 0;
  int               rx_held = 0;
  bit               rx_hold = 0;
  int               pix_left = 0;
  int               line_left = 0;
  int               n_sent = 0;
  int               n_ret = 0;

  // Model state
  logic [PIX_W-1:0] exp_q[$];
  int               m_phase;
  logic [3:0]       m_sync;
  logic [6:0]       m_r;
  logic [6:0]       m_g;
  bit               st1_v;
  logic [3:0]       st1_sync;
  logic [6:0]       st1_r;
  logic [6:0]       st1_g;
  logic [6:0]       st1_b;
  bit               st2_v;
  logic [PIX_W-1:0] st2_pix;
  bit               m_odd;
  bit               m_hs_prev;
  bit               m_vs_prev;
  int               m_count;
  int               m_credits;
  bit               m_sent;
  bit               m_ovf;

  n64_ppu_top dut_i (
    .N64_CLK_i       (clk),
    .arst_n_i        (arst_n),
    .nVDSYNC_i       (nvdsync),
    .VD_i            (vd_bus),
    .n16bit_mode_i   (n16bit),
    .sl_en_i         (sl_en),
    .sl_str_i        (sl_str),
    .credit_return_i (credit_return),
    .vd_valid_o      (vd_valid_o),
    .VD_o            (VD_o),
    .sync_o          (sync_o),
    .overflow_o      (overflow_o)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] rand_u32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Reduce, expand and dim one colour with plain integer arithmetic
  function automatic int model_color(int c, bit reduce, bit dim, int str);
    int v;
    v = reduce ? (c / 4) * 4 : c;
    v = v * 2 + v / 64;
    if (dim)
      v = v - (v * str) / 256;
    return v;
  endfunction

  task automatic check(input bit cond, input string msg);
    assert (cond) else begin
      $display("CHECK FAILED at time %0t: %s", $time, msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the pipeline did not drain", cycle_cnt);
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ============================================================
  // Output checks and reference model
  // ============================================================

  always @(posedge clk) begin : model_and_check
    logic [PIX_W-1:0] exp_pix;
    bit               arrive;
    bit               send;
    bit               stored;
    bit               dim;
    if (!arst_n) begin
      // First edge may still see outputs before the reset took effect
      if (reset_edges > 0) begin
        check(vd_valid_o === 1'b0, "vd_valid_o high during reset");
        check(overflow_o === 1'b0, "overflow_o high during reset");
      end
      reset_edges++;
      m_phase   = 0;
      st1_v     = 0;
      st2_v     = 0;
      m_odd     = 0;
      m_hs_prev = 1;
      m_vs_prev = 1;
      m_count   = 0;
      m_credits = `PPU_TX_CREDITS;
      m_sent    = 0;
      m_ovf     = 0;
    end else begin
      check(vd_valid_o === m_sent, $sformatf("vd_valid_o %b, model send %b", vd_valid_o, m_sent));
      if (vd_valid_o) begin
        exp_pix = exp_q.pop_front();
        check({sync_o, VD_o} === exp_pix,
              $sformatf("pixel sync %h rgb %h, expected sync %h rgb %h", sync_o, VD_o,
                        exp_pix[PIX_W-1:3*`PPU_COLOR_W], exp_pix[3*`PPU_COLOR_W-1:0]));
        n_sent++;
        rx_held++;
      end
      check(overflow_o === m_ovf, $sformatf("overflow_o %b, model %b", overflow_o, m_ovf));
      if (credit_return) begin
        n_ret++;
        rx_held--;
      end
      check(n_sent <= `PPU_TX_CREDITS + n_ret, "more sends than credits given");

      // Output buffer sees the pixel that left the scanline stage
      arrive = st2_v;
      send   = (m_credits > 0) && (m_count > 0 || arrive);
      stored = 0;
      if (arrive) begin
        if (m_count == `PPU_BUF_DEPTH) begin
          m_ovf = 1;
        end else begin
          exp_q.push_back(st2_pix);
          stored = !(m_count == 0 && m_credits > 0);
        end
      end
      m_count = m_count + int'(stored) - int'(send && m_count > 0);
      if (send && !credit_return)
        m_credits--;
      else if (!send && credit_return)
        m_credits++;
      m_sent = send;

      // Scanline stage with the mode inputs of this edge
      if (st1_v) begin
        if (!st1_sync[SYNC_NVSYNC] && m_vs_prev)
          m_odd = 0;
        else if (!st1_sync[SYNC_NHSYNC] && m_hs_prev)
          m_odd = !m_odd;
        m_hs_prev = st1_sync[SYNC_NHSYNC];
        m_vs_prev = st1_sync[SYNC_NVSYNC];
        dim = sl_en && m_odd;
        st2_pix = {st1_sync, 8'(model_color(st1_r, n16bit, dim, sl_str)),
                   8'(model_color(st1_g, n16bit, dim, sl_str)),
                   8'(model_color(st1_b, n16bit, dim, sl_str))};
      end
      st2_v = st1_v;

      // Bus demux
      st1_v = 0;
      if (!nvdsync) begin
        m_phase = 1;
        m_sync  = vd_bus.color[3:0];
      end else if (m_phase != 0) begin
        case (m_phase)
          1: m_r = vd_bus.color;
          2: m_g = vd_bus.color;
          default: begin
            st1_v    = 1;
            st1_sync = m_sync;
            st1_r    = m_r;
            st1_g    = m_g;
            st1_b    = vd_bus.color;
          end
        endcase
        m_phase = (m_phase == 3) ? 0 : m_phase + 1;
      end
    end
  end

  // ============================================================
  // Stimulus
  // ============================================================

  // Advances one cycle and lets the receiver decide on a credit return
  task automatic step_cycle();
    @(posedge clk);
    #1;
    credit_return = 1'b0;
    if (!rx_hold && rx_held > 0 && ((rand_u32() >> 20) % 3) != 0)
      credit_return = 1'b1;
  endtask

  task automatic run_groups(input int n_groups, input bit en, input bit reduce);
    int i;
    int k;
    int idle;
    bit hs_bit;
    bit vs_bit;
    for (i = 0; i < n_groups; i++) begin
      hs_bit = 1;
      vs_bit = 1;
      // Short lines of 3 to 6 pixels and frames of 2 to 4 lines
      if (pix_left == 0) begin
        pix_left = 3 + (rand_u32() >> 16) % 4;
        hs_bit   = 0;
        if (line_left == 0) begin
          line_left = 2 + (rand_u32() >> 16) % 3;
          vs_bit    = 0;
        end
        line_left--;
      end
      pix_left--;
      step_cycle();
      sl_en  = en;
      n16bit = reduce;
      if (en)
        sl_str = 8'(rand_u32() >> 12);
      nvdsync      = 1'b0;
      vd_bus.color = {3'(rand_u32() >> 29), vs_bit, 1'(rand_u32() >> 27), hs_bit,
                      1'(rand_u32() >> 26)};
      for (k = 0; k < 3; k++) begin
        step_cycle();
        nvdsync      = 1'b1;
        vd_bus.color = 7'(rand_u32() >> 9);
      end
      idle = (rand_u32() >> 18) % 4;
      repeat (idle) begin
        step_cycle();
        vd_bus.color = 7'(rand_u32() >> 9);
      end
    end
  endtask

  initial begin
    arst_n        = 1'b0;
    nvdsync       = 1'b1;
    vd_bus        = '0;
    n16bit        = 1'b0;
    sl_en         = 1'b0;
    sl_str        = '0;
    credit_return = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    run_groups(40, 1'b0, 1'b0);
    run_groups(30, 1'b0, 1'b1);
    run_groups(30, 1'b1, 1'b0);
    run_groups(30, 1'b1, 1'b1);

    // Receiver stalls while the N64 keeps sending
    rx_hold = 1;
    run_groups(30, 1'b1, 1'b0);
    rx_hold = 0;

    repeat (4) step_cycle();
    while (exp_q.size() != 0 || st1_v || st2_v)
      step_cycle();
    repeat (2) step_cycle();
    check(m_ovf && overflow_o === 1'b1, "overflow_o not set after the stalled receiver");
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
